// File: list.f
+incdir+hw
hw/id_pkg.sv
hw/fetch_ctrl.sv
hw/pc_counter.sv
hw/inst_decoder.sv
hw/reg_file.sv
hw/branch_unit.sv
hw/id_top.sv
bench/wb_mem_model.sv
bench/tb_id_top.sv

// File: bench/tb_id_top.sv
`timescale 1ns/100ps
`include "id_defines.svh"

module tb_id_top;
	localparam logic [31:0] FILL       = 32'h0000_0021;   // ADDU r0, r0, r0
	localparam logic [31:0] FIRST_WORD = {`ID_OP_ORI, 5'd0, 5'd5, 16'h00A5};

	logic                  clk;
	logic                  rst;
	logic                  wbm_cyc;
	logic                  wbm_stb;
	logic [`ID_XLEN-1:0]   wbm_adr;
	logic [`ID_XLEN-1:0]   wbm_dat;
	logic                  wbm_ack;
	logic                  rf_we;
	logic [`ID_REG_AW-1:0] rf_waddr;
	logic [`ID_XLEN-1:0]   rf_wdata;
	logic                  out_ready;
	logic                  out_valid;
	logic [`ID_XLEN-1:0]   pc;
	id_pkg::alu_sel_e      alusel;
	id_pkg::alu_op_e       aluop;
	logic [`ID_XLEN-1:0]   reg1;
	logic [`ID_XLEN-1:0]   reg2;
	logic [`ID_REG_AW-1:0] wd;
	logic                  wreg;
	logic [`ID_XLEN-1:0]   link_addr;
	logic                  in_dslot;
	id_pkg::exc_code_e     exc_code;
	logic [`ID_XLEN-1:0]   exc_epc;
	logic [`ID_XLEN-1:0]   exc_badvaddr;

	int          errors;
	int          test_start;
	int          n_pass;
	int          n_fail;
	logic [31:0] exp_pc;
	logic [31:0] cur_pc;
	logic [31:0] last_adr;
	logic [31:0] rv [32];          // Expected register contents
	bit          pending;          // An issued item is held, not yet accepted
	logic        bad_bus;
	integer      seed;

	id_top dut_i (
		.clk(clk), .rst(rst),
		.wbm_cyc_o(wbm_cyc), .wbm_stb_o(wbm_stb), .wbm_adr_o(wbm_adr),
		.wbm_dat_i(wbm_dat), .wbm_ack_i(wbm_ack),
		.rf_we_i(rf_we), .rf_waddr_i(rf_waddr), .rf_wdata_i(rf_wdata),
		.out_ready_i(out_ready), .out_valid_o(out_valid),
		.pc_o(pc), .alusel_o(alusel), .aluop_o(aluop), .reg1_o(reg1), .reg2_o(reg2),
		.wd_o(wd), .wreg_o(wreg), .link_addr_o(link_addr), .in_delayslot_o(in_dslot),
		.exc_code_o(exc_code), .exc_epc_o(exc_epc), .exc_badvaddr_o(exc_badvaddr)
	);

	wb_mem_model u_mem (
		.clk(clk), .rst(rst), .cyc_i(wbm_cyc), .stb_i(wbm_stb),
		.adr_i(wbm_adr), .dat_o(wbm_dat), .ack_o(wbm_ack)
	);

	always #4 clk = ~clk;

	// Bus monitor
	always @(posedge clk) begin
		if (wbm_cyc && wbm_ack) begin
			last_adr <= wbm_adr;
		end
		if (wbm_cyc && wbm_adr[1:0] != 2'b00) begin
			bad_bus <= 1'b1;
		end
	end

	////////////////////
	// Compare tasks
	task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			$display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic check_op(input id_pkg::alu_op_e exp, input id_pkg::alu_op_e act);
		if (act !== exp) begin
			$display("[FAIL] %0t aluop_o expected %s got %s", $time, exp.name(), act.name());
			errors++;
		end
	endtask

	task automatic check_sel(input id_pkg::alu_sel_e exp, input id_pkg::alu_sel_e act);
		if (act !== exp) begin
			$display("[FAIL] %0t alusel_o expected %s got %s", $time, exp.name(), act.name());
			errors++;
		end
	endtask

	task automatic check_exc(input id_pkg::exc_code_e exp, input id_pkg::exc_code_e act);
		if (act !== exp) begin
			$display("[FAIL] %0t exc_code_o expected %s got %s", $time, exp.name(), act.name());
			errors++;
		end
	endtask

	////////////////////
	// Driving helpers
	task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
		@(negedge clk);
		rf_we    = 1'b1;
		rf_waddr = addr;
		rf_wdata = data;
		@(negedge clk);
		rf_we = 1'b0;
		if (addr != 0) begin
			rv[addr] = data;
		end
	endtask

	// Place word at the next PC, release the held item, wait for the new one
	task automatic issue(input logic [31:0] word, output bit ok);
		int cnt;
		u_mem.mem[exp_pc[11:2]] = word;
		if (pending) begin
			out_ready = 1'b1;
			@(posedge clk);
			@(negedge clk);
			out_ready = 1'b0;
		end
		cnt = 0;
		while (!out_valid && cnt < 200) begin
			@(negedge clk);
			cnt++;
		end
		pending = out_valid;
		ok      = out_valid;
		if (!out_valid) begin
			$display("Timeout: nothing issued for pc %h within 200 cycles", exp_pc);
			errors++;
		end else begin
			cur_pc = exp_pc;
			check_word("pc_o", exp_pc, pc);
			if (exp_pc[1:0] == 2'b00) begin
				check_word("wbm_adr_o", exp_pc, last_adr);
			end
			exp_pc = exp_pc + 4;
		end
	endtask

	task automatic finish_test(input string name);
		if (errors == test_start) begin
			n_pass++;
			$display("%s: passed", name);
		end else begin
			n_fail++;
			$display("%s: failed", name);
		end
		test_start = errors;
	endtask

	task automatic alu_case(input logic [31:0] word, input id_pkg::alu_op_e op,
			input id_pkg::alu_sel_e sel, input logic [4:0] dst,
			input logic [31:0] r1, input logic [31:0] r2);
		bit ok;
		issue(word, ok);
		if (ok) begin
			check_op(op, aluop);
			check_sel(sel, alusel);
			check_word("wd_o", {27'd0, dst}, {27'd0, wd});
			check_word("wreg_o", 32'd1, {31'd0, wreg});
			check_word("reg1_o", r1, reg1);
			check_word("reg2_o", r2, reg2);
			check_exc(id_pkg::EC_NONE, exc_code);
			check_word("in_delayslot_o", 32'd0, {31'd0, in_dslot});
		end
	endtask

	////////////////////
	// Tests
	task automatic test_fetch;
		int n;
		logic [31:0] s_pc;
		logic [31:0] s_reg2;
		id_pkg::alu_op_e s_op;
		alu_case(FIRST_WORD, id_pkg::OP_ORI, id_pkg::SEL_LOGIC, 5'd5, 0, 32'h0000_00A5);
		alu_case({`ID_OP_ORI, 5'd0, 5'd6, 16'h1234}, id_pkg::OP_ORI, id_pkg::SEL_LOGIC,
			5'd6, 0, 32'h0000_1234);
		alu_case({`ID_OP_ADDIU, 5'd0, 5'd7, 16'hFFF0}, id_pkg::OP_ADDIU, id_pkg::SEL_ARITH,
			5'd7, 0, 32'hFFFF_FFF0);
		n      = 1 + ($unsigned($random(seed)) % 10);
		s_pc   = pc;
		s_reg2 = reg2;
		s_op   = aluop;
		repeat (n) begin
			@(negedge clk);
			check_word("out_valid_o", 32'd1, {31'd0, out_valid});
			check_word("wbm_cyc_o", 32'd0, {31'd0, wbm_cyc});
			check_word("wbm_stb_o", 32'd0, {31'd0, wbm_stb});
			check_word("pc_o", s_pc, pc);
			check_word("reg2_o", s_reg2, reg2);
			check_op(s_op, aluop);
		end
		finish_test("fetch_backpressure");
	endtask

	task automatic test_arith;
		write_reg(1, 32'h1234_5678);
		write_reg(2, 32'hFFFF_F000);
		alu_case({`ID_OP_SPECIAL, 5'd1, 5'd2, 5'd10, 5'd0, `ID_FN_ADDU}, id_pkg::OP_ADDU,
			id_pkg::SEL_ARITH, 5'd10, rv[1], rv[2]);
		@(negedge clk);
		rf_we    = 1'b1;                 // Bypass while the item is held
		rf_waddr = 5'd2;
		rf_wdata = 32'hCAFE_0002;
		#1;
		check_word("reg2_o bypass", 32'hCAFE_0002, reg2);
		@(negedge clk);
		rf_we = 1'b0;
		rv[2] = 32'hCAFE_0002;
		alu_case({`ID_OP_SPECIAL, 5'd1, 5'd2, 5'd11, 5'd0, `ID_FN_SUBU}, id_pkg::OP_SUBU,
			id_pkg::SEL_ARITH, 5'd11, rv[1], rv[2]);
		alu_case({`ID_OP_SPECIAL, 5'd1, 5'd2, 5'd12, 5'd0, `ID_FN_SLT}, id_pkg::OP_SLT,
			id_pkg::SEL_ARITH, 5'd12, rv[1], rv[2]);
		alu_case({`ID_OP_SPECIAL, 5'd1, 5'd2, 5'd13, 5'd0, `ID_FN_SLTU}, id_pkg::OP_SLTU,
			id_pkg::SEL_ARITH, 5'd13, rv[1], rv[2]);
		alu_case({`ID_OP_SPECIAL, 5'd1, 5'd2, 5'd14, 5'd0, `ID_FN_AND}, id_pkg::OP_AND,
			id_pkg::SEL_LOGIC, 5'd14, rv[1], rv[2]);
		alu_case({`ID_OP_SPECIAL, 5'd1, 5'd2, 5'd15, 5'd0, `ID_FN_OR}, id_pkg::OP_OR,
			id_pkg::SEL_LOGIC, 5'd15, rv[1], rv[2]);
		alu_case({`ID_OP_SPECIAL, 5'd1, 5'd2, 5'd16, 5'd0, `ID_FN_XOR}, id_pkg::OP_XOR,
			id_pkg::SEL_LOGIC, 5'd16, rv[1], rv[2]);
		alu_case({`ID_OP_SPECIAL, 5'd1, 5'd2, 5'd17, 5'd0, `ID_FN_NOR}, id_pkg::OP_NOR,
			id_pkg::SEL_LOGIC, 5'd17, rv[1], rv[2]);
		alu_case({`ID_OP_ADDIU, 5'd1, 5'd3, 16'h8001}, id_pkg::OP_ADDIU, id_pkg::SEL_ARITH,
			5'd3, rv[1], 32'hFFFF_8001);
		alu_case({`ID_OP_SLTI, 5'd1, 5'd3, 16'h8001}, id_pkg::OP_SLTI, id_pkg::SEL_ARITH,
			5'd3, rv[1], 32'hFFFF_8001);
		alu_case({`ID_OP_SLTIU, 5'd1, 5'd3, 16'h8001}, id_pkg::OP_SLTIU, id_pkg::SEL_ARITH,
			5'd3, rv[1], 32'hFFFF_8001);
		alu_case({`ID_OP_ANDI, 5'd1, 5'd3, 16'h8001}, id_pkg::OP_ANDI, id_pkg::SEL_LOGIC,
			5'd3, rv[1], 32'h0000_8001);
		alu_case({`ID_OP_ORI, 5'd1, 5'd3, 16'h8001}, id_pkg::OP_ORI, id_pkg::SEL_LOGIC,
			5'd3, rv[1], 32'h0000_8001);
		alu_case({`ID_OP_XORI, 5'd1, 5'd3, 16'h8001}, id_pkg::OP_XORI, id_pkg::SEL_LOGIC,
			5'd3, rv[1], 32'h0000_8001);
		alu_case({`ID_OP_LUI, 5'd1, 5'd3, 16'h8001}, id_pkg::OP_LUI, id_pkg::SEL_LOGIC,
			5'd3, 0, 32'h8001_0000);
		finish_test("arith_logic_decode");
	endtask

	// Branch at P, slot at P+4, then target or P+8
	task automatic branch_case(input logic [31:0] word, input id_pkg::alu_op_e op,
			input bit taken);
		bit ok;
		logic [31:0] p;
		logic [31:0] tgt;
		issue(word, ok);
		if (ok) begin
			p   = cur_pc;
			tgt = p + 4 + {{14{word[15]}}, word[15:0], 2'b00};
			check_op(op, aluop);
			check_sel(id_pkg::SEL_BRANCH, alusel);
			issue(FILL, ok);
			if (ok) begin
				check_word("in_delayslot_o", 32'd1, {31'd0, in_dslot});
				exp_pc = taken ? tgt : p + 8;
			end
		end
	endtask

	task automatic test_branches;
		bit ok;
		write_reg(4, 32'd5);
		write_reg(5, 32'd5);
		write_reg(6, 32'hFFFF_FFFD);
		write_reg(7, 32'd7);
		branch_case({`ID_OP_BEQ, 5'd4, 5'd5, 16'd3}, id_pkg::OP_BEQ, 1);
		branch_case({`ID_OP_BEQ, 5'd4, 5'd7, 16'd3}, id_pkg::OP_BEQ, 0);
		branch_case({`ID_OP_BNE, 5'd4, 5'd7, 16'hFFF9}, id_pkg::OP_BNE, 1);
		branch_case({`ID_OP_BNE, 5'd4, 5'd5, 16'd3}, id_pkg::OP_BNE, 0);
		branch_case({`ID_OP_REGIMM, 5'd4, `ID_RT_BGEZ, 16'd3}, id_pkg::OP_BGEZ, 1);
		branch_case({`ID_OP_REGIMM, 5'd6, `ID_RT_BGEZ, 16'd3}, id_pkg::OP_BGEZ, 0);
		branch_case({`ID_OP_REGIMM, 5'd6, `ID_RT_BLTZ, 16'd5}, id_pkg::OP_BLTZ, 1);
		branch_case({`ID_OP_REGIMM, 5'd4, `ID_RT_BLTZ, 16'd3}, id_pkg::OP_BLTZ, 0);
		branch_case({`ID_OP_BGTZ, 5'd4, 5'd0, 16'd3}, id_pkg::OP_BGTZ, 1);
		branch_case({`ID_OP_BGTZ, 5'd0, 5'd0, 16'd3}, id_pkg::OP_BGTZ, 0);
		branch_case({`ID_OP_BLEZ, 5'd0, 5'd0, 16'd4}, id_pkg::OP_BLEZ, 1);
		branch_case({`ID_OP_BLEZ, 5'd4, 5'd0, 16'd3}, id_pkg::OP_BLEZ, 0);
		issue(FILL, ok);
		if (ok) begin
			check_word("in_delayslot_o", 32'd0, {31'd0, in_dslot});
		end
		finish_test("conditional_branches");
	endtask

	task automatic jump_case(input logic [31:0] word, input id_pkg::alu_op_e op,
			input logic [31:0] tgt, input bit link, input logic [4:0] dst);
		bit ok;
		issue(word, ok);
		if (ok) begin
			check_op(op, aluop);
			check_word("link_addr_o", link ? cur_pc + 8 : 32'd0, link_addr);
			if (link) begin
				check_word("wd_o", {27'd0, dst}, {27'd0, wd});
				check_word("wreg_o", 32'd1, {31'd0, wreg});
			end
			issue(FILL, ok);
			if (ok) begin
				check_word("in_delayslot_o", 32'd1, {31'd0, in_dslot});
				exp_pc = tgt;
			end
		end
	endtask

	task automatic test_jumps;
		bit ok;
		write_reg(8, 32'h0000_0800);
		write_reg(10, 32'h0000_0900);
		jump_case({`ID_OP_J, 26'h180}, id_pkg::OP_J, 32'h0000_0600, 0, 5'd0);
		jump_case({`ID_OP_JAL, 26'h1C0}, id_pkg::OP_JAL, 32'h0000_0700, 1, `ID_LINK_REG);
		jump_case({`ID_OP_SPECIAL, 5'd8, 5'd0, 5'd0, 5'd0, `ID_FN_JR}, id_pkg::OP_JR,
			32'h0000_0800, 0, 5'd0);
		jump_case({`ID_OP_SPECIAL, 5'd10, 5'd0, 5'd9, 5'd0, `ID_FN_JALR}, id_pkg::OP_JALR,
			32'h0000_0900, 1, 5'd9);
		issue(FILL, ok);
		finish_test("jumps");
	endtask

	task automatic test_reserved;
		bit ok;
		logic [31:0] p;
		issue(32'hFC00_0000, ok);
		if (ok) begin
			check_exc(id_pkg::EC_RI, exc_code);
			check_word("exc_badvaddr_o", 32'hFC00_0000, exc_badvaddr);
			check_word("wreg_o", 32'd0, {31'd0, wreg});
			check_word("exc_epc_o", cur_pc, exc_epc);
			check_op(id_pkg::OP_NOP, aluop);
		end
		issue({`ID_OP_BEQ, 5'd0, 5'd0, 16'd2}, ok);
		p = cur_pc;
		issue(32'h0000_003F, ok);        // Reserved SPECIAL function in the slot
		if (ok) begin
			check_exc(id_pkg::EC_RI, exc_code);
			check_word("in_delayslot_o", 32'd1, {31'd0, in_dslot});
			check_word("exc_epc_o", cur_pc - 4, exc_epc);
			exp_pc = p + 12;
		end
		issue(FILL, ok);
		finish_test("reserved_instruction");
	endtask

	task automatic test_misaligned;
		bit ok;
		write_reg(11, 32'h0000_0A02);
		issue({`ID_OP_SPECIAL, 5'd11, 5'd0, 5'd0, 5'd0, `ID_FN_JR}, ok);
		issue(FILL, ok);
		exp_pc = 32'h0000_0A02;
		issue(FILL, ok);
		if (ok) begin
			check_exc(id_pkg::EC_ADEL, exc_code);
			check_word("exc_badvaddr_o", 32'h0000_0A02, exc_badvaddr);
			check_op(id_pkg::OP_NOP, aluop);
			check_word("wreg_o", 32'd0, {31'd0, wreg});
			check_word("bus cycle at misaligned address", 32'd0, {31'd0, bad_bus});
		end
		finish_test("misaligned_jump");
	endtask

	initial begin
		clk        = 1'b0;
		rst        = 1'b1;
		rf_we      = 1'b0;
		rf_waddr   = '0;
		rf_wdata   = '0;
		out_ready  = 1'b0;
		errors     = 0;
		test_start = 0;
		n_pass     = 0;
		n_fail     = 0;
		exp_pc     = `ID_RESET_PC;
		last_adr   = 32'hFFFF_FFFF;
		pending    = 0;
		bad_bus    = 1'b0;
		seed       = 49322;
		for (int k = 0; k < 32; k++) begin
			rv[k] = '0;
		end
		#1;
		u_mem.mem[0] = FIRST_WORD;       // Fetched right after reset
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		test_fetch();
		test_arith();
		test_branches();
		test_jumps();
		test_reserved();
		test_misaligned();
		$display("Tests: %0d passed, %0d failed, %0d check errors", n_pass, n_fail, errors);
		if (n_fail == 0 && errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// File: bench/wb_mem_model.sv
`timescale 1ns/100ps
`include "id_defines.svh"

module wb_mem_model (
	input  logic                clk,
	input  logic                rst,
	input  logic                cyc_i,
	input  logic                stb_i,
	input  logic [`ID_XLEN-1:0] adr_i,
	output logic [`ID_XLEN-1:0] dat_o,
	output logic                ack_o
);
	localparam int DEPTH = 1024;      // 4 KB of words

	logic [`ID_XLEN-1:0] mem [DEPTH];
	logic                busy;
	int                  cnt;
	integer              seed;

	initial begin
		seed = 49322;
		for (int k = 0; k < DEPTH; k++) begin
			mem[k] = {`ID_OP_ORI, 5'd0, 5'd0, 16'(k)};   // ORI word tagged with its index
		end
	end

	always @(posedge clk) begin
		int d;
		if (rst) begin
			ack_o <= 1'b0;
			busy  <= 1'b0;
			cnt   <= 0;
		end else if (ack_o) begin
			ack_o <= 1'b0;                // Single-cycle acknowledge
			busy  <= 1'b0;
		end else if (cyc_i && stb_i) begin
			if (!busy) begin
				d = $unsigned($random(seed)) % 4;
				if (d == 0) begin
					ack_o <= 1'b1;
					dat_o <= mem[adr_i[11:2]];
				end else begin
					busy <= 1'b1;
					cnt  <= d - 1;
				end
			end else if (cnt == 0) begin
				ack_o <= 1'b1;
				dat_o <= mem[adr_i[11:2]];
			end else begin
				cnt <= cnt - 1;
			end
		end
	end

endmodule

// File: hw/id_top.sv
`timescale 1ns/100ps
`include "id_defines.svh"

module id_top (
	input  logic                  clk,
	input  logic                  rst,
	output logic                  wbm_cyc_o,
	output logic                  wbm_stb_o,
	output logic [`ID_XLEN-1:0]   wbm_adr_o,
	input  logic [`ID_XLEN-1:0]   wbm_dat_i,
	input  logic                  wbm_ack_i,
	input  logic                  rf_we_i,
	input  logic [`ID_REG_AW-1:0] rf_waddr_i,
	input  logic [`ID_XLEN-1:0]   rf_wdata_i,
	input  logic                  out_ready_i,
	output logic                  out_valid_o,
	output logic [`ID_XLEN-1:0]   pc_o,
	output id_pkg::alu_sel_e      alusel_o,
	output id_pkg::alu_op_e       aluop_o,
	output logic [`ID_XLEN-1:0]   reg1_o,
	output logic [`ID_XLEN-1:0]   reg2_o,
	output logic [`ID_REG_AW-1:0] wd_o,
	output logic                  wreg_o,
	output logic [`ID_XLEN-1:0]   link_addr_o,
	output logic                  in_delayslot_o,
	output id_pkg::exc_code_e     exc_code_o,
	output logic [`ID_XLEN-1:0]   exc_epc_o,
	output logic [`ID_XLEN-1:0]   exc_badvaddr_o
);
	id_pkg::inst_t         inst;
	logic                  pc_misaligned;
	logic                  issue_done;
	logic                  is_branch;
	logic                  branch_taken;
	logic [`ID_XLEN-1:0]   branch_target;
	logic [`ID_REG_AW-1:0] rs_addr;
	logic [`ID_REG_AW-1:0] rt_addr;
	logic                  rs_read;
	logic                  rt_read;
	logic [`ID_XLEN-1:0]   imm;
	logic [`ID_XLEN-1:0]   rs_data;
	logic [`ID_XLEN-1:0]   rt_data;

	fetch_ctrl u_fetch (
		.clk(clk), .rst(rst),
		.pc_i(pc_o), .pc_misaligned_i(pc_misaligned),
		.wbm_cyc_o(wbm_cyc_o), .wbm_stb_o(wbm_stb_o), .wbm_adr_o(wbm_adr_o),
		.wbm_dat_i(wbm_dat_i), .wbm_ack_i(wbm_ack_i),
		.out_ready_i(out_ready_i), .out_valid_o(out_valid_o),
		.inst_o(inst), .issue_done_o(issue_done)
	);

	pc_counter u_pc (
		.clk(clk), .rst(rst),
		.issue_done_i(issue_done), .is_branch_i(is_branch),
		.branch_taken_i(branch_taken), .branch_target_i(branch_target),
		.pc_o(pc_o), .pc_misaligned_o(pc_misaligned), .in_delayslot_o(in_delayslot_o)
	);

	inst_decoder u_dec (
		.inst_i(inst), .pc_i(pc_o), .pc_misaligned_i(pc_misaligned),
		.in_delayslot_i(in_delayslot_o),
		.alusel_o(alusel_o), .aluop_o(aluop_o),
		.rs_addr_o(rs_addr), .rt_addr_o(rt_addr), .rs_read_o(rs_read), .rt_read_o(rt_read),
		.imm_o(imm), .wd_o(wd_o), .wreg_o(wreg_o),
		.exc_code_o(exc_code_o), .exc_epc_o(exc_epc_o), .exc_badvaddr_o(exc_badvaddr_o)
	);

	reg_file u_rf (
		.clk(clk), .rst(rst),
		.rf_we_i(rf_we_i), .rf_waddr_i(rf_waddr_i), .rf_wdata_i(rf_wdata_i),
		.rs_addr_i(rs_addr), .rt_addr_i(rt_addr),
		.rs_data_o(rs_data), .rt_data_o(rt_data)
	);

	branch_unit u_br (
		.aluop_i(aluop_o), .pc_i(pc_o),
		.rs_read_i(rs_read), .rt_read_i(rt_read),
		.rs_data_i(rs_data), .rt_data_i(rt_data),
		.imm_i(imm), .target26_i(inst.j.target26),
		.reg1_o(reg1_o), .reg2_o(reg2_o), .is_branch_o(is_branch),
		.branch_taken_o(branch_taken), .branch_target_o(branch_target),
		.link_addr_o(link_addr_o)
	);

endmodule

// File: hw/branch_unit.sv
`timescale 1ns/100ps
`include "id_defines.svh"

module branch_unit (
	input  id_pkg::alu_op_e     aluop_i,
	input  logic [`ID_XLEN-1:0] pc_i,
	input  logic                rs_read_i,
	input  logic                rt_read_i,
	input  logic [`ID_XLEN-1:0] rs_data_i,
	input  logic [`ID_XLEN-1:0] rt_data_i,
	input  logic [`ID_XLEN-1:0] imm_i,
	input  logic [25:0]         target26_i,
	output logic [`ID_XLEN-1:0] reg1_o,
	output logic [`ID_XLEN-1:0] reg2_o,
	output logic                is_branch_o,
	output logic                branch_taken_o,
	output logic [`ID_XLEN-1:0] branch_target_o,
	output logic [`ID_XLEN-1:0] link_addr_o
);
	logic [`ID_XLEN-1:0] pc_plus4;
	logic [`ID_XLEN-1:0] br_target;
	logic [`ID_XLEN-1:0] j_target;
	logic                rs_neg;
	logic                rs_zero;

	assign reg1_o    = rs_read_i ? rs_data_i : '0;
	assign reg2_o    = rt_read_i ? rt_data_i : imm_i;
	assign rs_neg    = reg1_o[`ID_XLEN-1];
	assign rs_zero   = (reg1_o == '0);
	assign pc_plus4  = pc_i + 32'd4;
	assign br_target = pc_plus4 + {imm_i[`ID_XLEN-3:0], 2'b00};          // Word offset
	assign j_target  = {pc_plus4[`ID_XLEN-1:`ID_XLEN-4], target26_i, 2'b00};  // Same 256 MB region

	always_comb begin
		is_branch_o    = 1'b1;
		branch_taken_o = 1'b0;
		case (aluop_i)
			id_pkg::OP_BEQ:  branch_taken_o = (reg1_o == reg2_o);
			id_pkg::OP_BNE:  branch_taken_o = (reg1_o != reg2_o);
			id_pkg::OP_BGEZ: branch_taken_o = !rs_neg;
			id_pkg::OP_BLTZ: branch_taken_o = rs_neg;
			id_pkg::OP_BGTZ: branch_taken_o = !rs_neg && !rs_zero;
			id_pkg::OP_BLEZ: branch_taken_o = rs_neg || rs_zero;
			id_pkg::OP_J, id_pkg::OP_JAL, id_pkg::OP_JR, id_pkg::OP_JALR: begin
				branch_taken_o = 1'b1;
			end
			default: is_branch_o = 1'b0;
		endcase
	end

	always_comb begin
		case (aluop_i)
			id_pkg::OP_J, id_pkg::OP_JAL:   branch_target_o = j_target;
			id_pkg::OP_JR, id_pkg::OP_JALR: branch_target_o = reg1_o;
			default:                        branch_target_o = br_target;
		endcase
	end

	// Return past the delay slot
	assign link_addr_o = (aluop_i == id_pkg::OP_JAL || aluop_i == id_pkg::OP_JALR) ?
		pc_i + 32'd8 : '0;

endmodule

// File: hw/reg_file.sv
`timescale 1ns/100ps
`include "id_defines.svh"

module reg_file (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  rf_we_i,
	input  logic [`ID_REG_AW-1:0] rf_waddr_i,
	input  logic [`ID_XLEN-1:0]   rf_wdata_i,
	input  logic [`ID_REG_AW-1:0] rs_addr_i,
	input  logic [`ID_REG_AW-1:0] rt_addr_i,
	output logic [`ID_XLEN-1:0]   rs_data_o,
	output logic [`ID_XLEN-1:0]   rt_data_o
);
	localparam int NREGS = 1 << `ID_REG_AW;

	logic [`ID_XLEN-1:0] regs_q [NREGS];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int k = 0; k < NREGS; k++) begin
				regs_q[k] <= '0;
			end
		end else if (rf_we_i && rf_waddr_i != '0) begin
			regs_q[rf_waddr_i] <= rf_wdata_i;   // Register zero never written
		end
	end

	// Write data bypasses the array in the same cycle
	assign rs_data_o = (rs_addr_i == '0) ? '0 :
		(rf_we_i && rf_waddr_i == rs_addr_i) ? rf_wdata_i : regs_q[rs_addr_i];
	assign rt_data_o = (rt_addr_i == '0) ? '0 :
		(rf_we_i && rf_waddr_i == rt_addr_i) ? rf_wdata_i : regs_q[rt_addr_i];

endmodule

// File: hw/inst_decoder.sv
`timescale 1ns/100ps
`include "id_defines.svh"

module inst_decoder (
	input  id_pkg::inst_t         inst_i,
	input  logic [`ID_XLEN-1:0]   pc_i,
	input  logic                  pc_misaligned_i,
	input  logic                  in_delayslot_i,
	output id_pkg::alu_sel_e      alusel_o,
	output id_pkg::alu_op_e       aluop_o,
	output logic [`ID_REG_AW-1:0] rs_addr_o,
	output logic [`ID_REG_AW-1:0] rt_addr_o,
	output logic                  rs_read_o,
	output logic                  rt_read_o,
	output logic [`ID_XLEN-1:0]   imm_o,
	output logic [`ID_REG_AW-1:0] wd_o,
	output logic                  wreg_o,
	output id_pkg::exc_code_e     exc_code_o,
	output logic [`ID_XLEN-1:0]   exc_epc_o,
	output logic [`ID_XLEN-1:0]   exc_badvaddr_o
);
	id_pkg::alu_op_e     op;
	id_pkg::alu_sel_e    sel;
	logic                rs_rd;
	logic                rt_rd;
	logic                wr;
	logic                reserved;
	logic                exc;
	logic [`ID_XLEN-1:0] imm_sext;
	logic [`ID_XLEN-1:0] imm_zext;

	assign imm_sext  = {{(`ID_XLEN-16){inst_i.i.imm16[15]}}, inst_i.i.imm16};
	assign imm_zext  = {{(`ID_XLEN-16){1'b0}}, inst_i.i.imm16};
	assign rs_addr_o = inst_i.r.rs;
	assign rt_addr_o = inst_i.r.rt;

	////////////////////
	// Opcode decode
	always_comb begin
		op       = id_pkg::OP_NOP;
		wd_o     = inst_i.i.rt;     // I-type destination
		imm_o    = imm_sext;        // Also the branch offset
		reserved = 1'b0;
		case (inst_i.r.op)
			`ID_OP_SPECIAL: begin
				wd_o  = inst_i.r.rd;
				imm_o = '0;
				case (inst_i.r.funct)
					`ID_FN_ADDU: op = id_pkg::OP_ADDU;
					`ID_FN_SUBU: op = id_pkg::OP_SUBU;
					`ID_FN_SLT:  op = id_pkg::OP_SLT;
					`ID_FN_SLTU: op = id_pkg::OP_SLTU;
					`ID_FN_AND:  op = id_pkg::OP_AND;
					`ID_FN_OR:   op = id_pkg::OP_OR;
					`ID_FN_XOR:  op = id_pkg::OP_XOR;
					`ID_FN_NOR:  op = id_pkg::OP_NOR;
					`ID_FN_JR:   op = id_pkg::OP_JR;
					`ID_FN_JALR: op = id_pkg::OP_JALR;
					default:     reserved = 1'b1;
				endcase
			end
			`ID_OP_REGIMM: begin
				case (inst_i.i.rt)
					`ID_RT_BLTZ: op = id_pkg::OP_BLTZ;
					`ID_RT_BGEZ: op = id_pkg::OP_BGEZ;
					default:     reserved = 1'b1;
				endcase
			end
			`ID_OP_BEQ:   op = id_pkg::OP_BEQ;
			`ID_OP_BNE:   op = id_pkg::OP_BNE;
			`ID_OP_BLEZ:  op = id_pkg::OP_BLEZ;
			`ID_OP_BGTZ:  op = id_pkg::OP_BGTZ;
			`ID_OP_J: begin
				op    = id_pkg::OP_J;
				imm_o = '0;
			end
			`ID_OP_JAL: begin
				op    = id_pkg::OP_JAL;
				wd_o  = `ID_LINK_REG;
				imm_o = '0;
			end
			`ID_OP_ADDIU: op = id_pkg::OP_ADDIU;
			`ID_OP_SLTI:  op = id_pkg::OP_SLTI;
			`ID_OP_SLTIU: op = id_pkg::OP_SLTIU;   // Sign-extended, compared unsigned
			`ID_OP_ANDI: begin
				op    = id_pkg::OP_ANDI;
				imm_o = imm_zext;
			end
			`ID_OP_ORI: begin
				op    = id_pkg::OP_ORI;
				imm_o = imm_zext;
			end
			`ID_OP_XORI: begin
				op    = id_pkg::OP_XORI;
				imm_o = imm_zext;
			end
			`ID_OP_LUI: begin
				op    = id_pkg::OP_LUI;
				imm_o = {inst_i.i.imm16, 16'h0000};
			end
			default: reserved = 1'b1;
		endcase
	end

	// Unit selector and operand usage per operation
	always_comb begin
		sel   = id_pkg::SEL_BRANCH;
		rs_rd = 1'b1;
		rt_rd = 1'b0;
		wr    = 1'b0;
		case (op)
			id_pkg::OP_ADDU, id_pkg::OP_SUBU, id_pkg::OP_SLT, id_pkg::OP_SLTU: begin
				sel   = id_pkg::SEL_ARITH;
				rt_rd = 1'b1;
				wr    = 1'b1;
			end
			id_pkg::OP_AND, id_pkg::OP_OR, id_pkg::OP_XOR, id_pkg::OP_NOR: begin
				sel   = id_pkg::SEL_LOGIC;
				rt_rd = 1'b1;
				wr    = 1'b1;
			end
			id_pkg::OP_ADDIU, id_pkg::OP_SLTI, id_pkg::OP_SLTIU: begin
				sel = id_pkg::SEL_ARITH;
				wr  = 1'b1;
			end
			id_pkg::OP_ANDI, id_pkg::OP_ORI, id_pkg::OP_XORI, id_pkg::OP_LUI: begin
				sel   = id_pkg::SEL_LOGIC;
				rs_rd = (op != id_pkg::OP_LUI);
				wr    = 1'b1;
			end
			id_pkg::OP_BEQ, id_pkg::OP_BNE: rt_rd = 1'b1;
			id_pkg::OP_JALR:                wr = 1'b1;
			id_pkg::OP_J:                   rs_rd = 1'b0;
			id_pkg::OP_JAL: begin
				rs_rd = 1'b0;
				wr    = 1'b1;
			end
			id_pkg::OP_NOP: begin
				sel   = id_pkg::SEL_NONE;
				rs_rd = 1'b0;
			end
			default: rs_rd = 1'b1;          // Remaining branches, JR
		endcase
	end

	////////////////////
	// Exceptions, fetch error first
	assign exc = pc_misaligned_i || reserved;

	always_comb begin
		exc_code_o     = id_pkg::EC_NONE;
		exc_badvaddr_o = '0;
		aluop_o        = op;
		alusel_o       = sel;
		if (pc_misaligned_i) begin
			exc_code_o     = id_pkg::EC_ADEL;
			exc_badvaddr_o = pc_i;
		end else if (reserved) begin
			exc_code_o     = id_pkg::EC_RI;
			exc_badvaddr_o = inst_i;
		end
		if (exc) begin
			aluop_o  = id_pkg::OP_NOP;
			alusel_o = id_pkg::SEL_NONE;
		end
	end

	assign wreg_o    = wr && !exc;
	assign rs_read_o = rs_rd && !exc;
	assign rt_read_o = rt_rd && !exc;
	assign exc_epc_o = in_delayslot_i ? pc_i - 32'd4 : pc_i;   // Slot reports its branch

endmodule

// File: hw/pc_counter.sv
`timescale 1ns/100ps
`include "id_defines.svh"

module pc_counter (
	input  logic               clk,
	input  logic               rst,
	input  logic               issue_done_i,
	input  logic               is_branch_i,
	input  logic               branch_taken_i,
	input  logic [`ID_XLEN-1:0] branch_target_i,
	output logic [`ID_XLEN-1:0] pc_o,
	output logic               pc_misaligned_o,
	output logic               in_delayslot_o
);
	logic [`ID_XLEN-1:0] pc_q;
	logic [`ID_XLEN-1:0] target_q;
	logic                dslot_q;     // Next issue is a delay slot
	logic                pending_q;   // Target waits behind the slot

	always_ff @(posedge clk) begin
		if (rst) begin
			pc_q      <= `ID_RESET_PC;
			dslot_q   <= 1'b0;
			pending_q <= 1'b0;
		end else if (issue_done_i) begin
			if (dslot_q && pending_q) begin
				pc_q <= target_q;
			end else begin
				pc_q <= pc_q + 32'd4;
			end
			dslot_q   <= !dslot_q && is_branch_i;
			pending_q <= !dslot_q && branch_taken_i;
		end
	end

	always_ff @(posedge clk) begin
		if (issue_done_i && branch_taken_i) begin
			target_q <= branch_target_i;
		end
	end

	assign pc_o            = pc_q;
	assign pc_misaligned_o = |pc_q[1:0];
	assign in_delayslot_o  = dslot_q;

	// A taken branch sitting in a delay slot would lose its target
	a_no_target_in_slot: assert property (@(posedge clk) disable iff (rst)
		issue_done_i && dslot_q |-> !branch_taken_i);

endmodule

// File: hw/fetch_ctrl.sv
`timescale 1ns/100ps
`include "id_defines.svh"

module fetch_ctrl (
	input  logic               clk,
	input  logic               rst,
	input  logic [`ID_XLEN-1:0] pc_i,
	input  logic               pc_misaligned_i,
	output logic               wbm_cyc_o,
	output logic               wbm_stb_o,
	output logic [`ID_XLEN-1:0] wbm_adr_o,
	input  logic [`ID_XLEN-1:0] wbm_dat_i,
	input  logic               wbm_ack_i,
	input  logic               out_ready_i,
	output logic               out_valid_o,
	output id_pkg::inst_t      inst_o,
	output logic               issue_done_o
);
	localparam logic [1:0] S_IDLE      = 2'd0;
	localparam logic [1:0] S_FETCH_REQ = 2'd1;
	localparam logic [1:0] S_ISSUE     = 2'd2;

	logic [1:0]    state_q;
	id_pkg::inst_t inst_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= S_IDLE;
		end else begin
			case (state_q)
				S_IDLE: state_q <= S_FETCH_REQ;
				S_FETCH_REQ: begin
					if (pc_misaligned_i || wbm_ack_i) begin
						state_q <= S_ISSUE;
					end
				end
				S_ISSUE: begin
					if (issue_done_o) begin
						state_q <= S_FETCH_REQ;   // Next fetch right after the transfer
					end
				end
				default: state_q <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == S_FETCH_REQ) begin
			if (pc_misaligned_i) begin
				inst_q <= '0;                  // Nothing fetched
			end else if (wbm_ack_i) begin
				inst_q <= wbm_dat_i;
			end
		end
	end

	assign wbm_cyc_o    = (state_q == S_FETCH_REQ) && !pc_misaligned_i;
	assign wbm_stb_o    = wbm_cyc_o;
	assign wbm_adr_o    = pc_i;                 // PC holds until issue
	assign out_valid_o  = (state_q == S_ISSUE);
	assign issue_done_o = out_valid_o && out_ready_i;
	assign inst_o       = inst_q;

	////////////////////
	// Bus and issue port rules
	a_bus_hold: assert property (@(posedge clk) disable iff (rst)
		wbm_stb_o && !wbm_ack_i |=> wbm_stb_o && $stable(wbm_adr_o));

	a_valid_hold: assert property (@(posedge clk) disable iff (rst)
		out_valid_o && !out_ready_i |=> out_valid_o && $stable(inst_o));

endmodule

// File: hw/id_pkg.sv
`include "id_defines.svh"

package id_pkg;

	// One fetched word, seen through the three MIPS formats
	typedef union packed {
		struct packed {
			logic [5:0]            op;
			logic [`ID_REG_AW-1:0] rs;
			logic [`ID_REG_AW-1:0] rt;
			logic [`ID_REG_AW-1:0] rd;
			logic [4:0]            shamt;
			logic [5:0]            funct;
		} r;
		struct packed {
			logic [5:0]            op;
			logic [`ID_REG_AW-1:0] rs;
			logic [`ID_REG_AW-1:0] rt;
			logic [15:0]           imm16;
		} i;
		struct packed {
			logic [5:0]  op;
			logic [25:0] target26;
		} j;
	} inst_t;

	typedef enum logic [2:0] {
		SEL_NONE,
		SEL_LOGIC,
		SEL_ARITH,
		SEL_BRANCH
	} alu_sel_e;

	typedef enum logic [7:0] {
		OP_NOP,
		OP_ADDU, OP_SUBU, OP_SLT, OP_SLTU,
		OP_AND, OP_OR, OP_XOR, OP_NOR,
		OP_ADDIU, OP_SLTI, OP_SLTIU,
		OP_ANDI, OP_ORI, OP_XORI, OP_LUI,
		OP_BEQ, OP_BNE, OP_BGEZ, OP_BLTZ, OP_BGTZ, OP_BLEZ,
		OP_J, OP_JAL, OP_JR, OP_JALR
	} alu_op_e;

	typedef enum logic [4:0] {
		EC_NONE = 5'd0,
		EC_ADEL = 5'd4,   // Fetch address error
		EC_RI   = 5'd10   // Reserved instruction
	} exc_code_e;

endpackage

// File: hw/id_defines.svh
`ifndef ID_DEFINES_SVH
`define ID_DEFINES_SVH

`define ID_XLEN       32
`define ID_REG_AW     5
`define ID_RESET_PC   32'h0000_0000
`define ID_LINK_REG   5'd31            // JAL writes here

////////////////////
// Primary opcodes
`define ID_OP_SPECIAL 6'b000000
`define ID_OP_REGIMM  6'b000001
`define ID_OP_J       6'b000010
`define ID_OP_JAL     6'b000011
`define ID_OP_BEQ     6'b000100
`define ID_OP_BNE     6'b000101
`define ID_OP_BLEZ    6'b000110
`define ID_OP_BGTZ    6'b000111
`define ID_OP_ADDIU   6'b001001
`define ID_OP_SLTI    6'b001010
`define ID_OP_SLTIU   6'b001011
`define ID_OP_ANDI    6'b001100
`define ID_OP_ORI     6'b001101
`define ID_OP_XORI    6'b001110
`define ID_OP_LUI     6'b001111

////////////////////
// SPECIAL function field
`define ID_FN_JR      6'b001000
`define ID_FN_JALR    6'b001001
`define ID_FN_ADDU    6'b100001
`define ID_FN_SUBU    6'b100011
`define ID_FN_AND     6'b100100
`define ID_FN_OR      6'b100101
`define ID_FN_XOR     6'b100110
`define ID_FN_NOR     6'b100111
`define ID_FN_SLT     6'b101010
`define ID_FN_SLTU    6'b101011

`define ID_RT_BLTZ    5'b00000         // REGIMM rt field
`define ID_RT_BGEZ    5'b00001

`endif
